// File: include/priv_params.svh
/* privileged unit parameters
   register width, hart id, reset vector and CSR addresses */
`ifndef PRIV_PARAMS_SVH
`define PRIV_PARAMS_SVH

`define XLEN         32
`define HART_ID      32'h0000_0000
`define RESET_PC     32'h0000_0100  // reset value of mtvec

// machine-mode CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MHARTID  12'hF14        // read only

`endif

// File: source/priv_isa_types_pkg.sv
/* privileged ISA types
   privilege levels, trap cause codes and the mstatus layout */
package priv_isa_types_pkg;

    // only U and M are implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_level_t;

    // bit 31 flags an interrupt, low bits hold the code
    typedef logic [31:0] cause_t;

    localparam cause_t CAUSE_MISALIGNED_FETCH = 32'd0;
    localparam cause_t CAUSE_ILLEGAL_INSN     = 32'd2;
    localparam cause_t CAUSE_BREAKPOINT       = 32'd3;
    localparam cause_t CAUSE_ECALL_U          = 32'd8;
    localparam cause_t CAUSE_ECALL_M          = 32'd11;
    localparam cause_t CAUSE_M_TIMER_INT      = {1'b1, 31'd7};
    localparam cause_t CAUSE_M_EXT_INT        = {1'b1, 31'd11};

    // reserved fields read as zero
    typedef struct packed {
        logic [18:0] reserved_31_13;
        priv_level_t mpp;            // 12:11
        logic [2:0]  reserved_10_8;
        logic        mpie;           // 7
        logic [2:0]  reserved_6_4;
        logic        mie;            // 3
        logic [2:0]  reserved_2_0;
    } mstatus_t;

endpackage

// File: source/priv_mode.sv
/* privilege level register
   enters M on a trap, returns to the stacked MPP on mret */
`timescale 1ns/1ps

module priv_mode (
    input  logic                            CLK,
    input  logic                            arst_n,
    input  logic                            trap_take,
    input  logic                            mret_take,
    input  priv_isa_types_pkg::priv_level_t mpp,
    output priv_isa_types_pkg::priv_level_t curr_level
);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            curr_level <= priv_isa_types_pkg::PRIV_M;  // hart boots in M
        end else if (trap_take) begin
            curr_level <= priv_isa_types_pkg::PRIV_M;
        end else if (mret_take) begin
            curr_level <= mpp;
        end
    end

endmodule

// File: source/priv_csr.sv
/* machine-mode CSR file
   swap/set/clear access with permission checks, trap and mret stack updates */
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_csr (
    input  logic                            CLK,
    input  logic                            arst_n,
    input  logic [11:0]                     csr_addr,
    input  logic                            csr_swap,
    input  logic                            csr_set,
    input  logic                            csr_clr,
    input  logic [`XLEN-1:0]                csr_wdata,
    input  priv_isa_types_pkg::priv_level_t curr_level,
    input  logic                            trap_take,
    input  priv_isa_types_pkg::cause_t      trap_cause,
    input  logic [`XLEN-1:0]                trap_epc,
    input  logic [`XLEN-1:0]                trap_val,
    input  logic                            mret_take,
    output logic [`XLEN-1:0]                csr_rdata,
    output logic                            invalid_priv_isn,
    output priv_isa_types_pkg::mstatus_t    mstatus,
    output logic [`XLEN-1:0]                mtvec,
    output logic [`XLEN-1:0]                mepc
);

    logic [`XLEN-1:0]             mscratch;
    logic [`XLEN-1:0]             mtval;
    priv_isa_types_pkg::cause_t   mcause;
    logic                         csr_access;
    logic                         csr_writes;
    logic                         addr_known;
    logic                         invalid;
    logic                         csr_we;
    logic [`XLEN-1:0]             old_val;
    logic [`XLEN-1:0]             new_val;
    priv_isa_types_pkg::mstatus_t mstatus_wr;

    assign csr_access = csr_swap | csr_set | csr_clr;
    // set or clear with an empty mask is a pure read
    assign csr_writes = csr_swap | ((csr_set | csr_clr) & (|csr_wdata));

    // address decode and old value
    always_comb begin
        addr_known = 1'b1;
        old_val    = '0;
        case (csr_addr)
            `CSR_MSTATUS:  old_val = mstatus;
            `CSR_MTVEC:    old_val = mtvec;
            `CSR_MSCRATCH: old_val = mscratch;
            `CSR_MEPC:     old_val = mepc;
            `CSR_MCAUSE:   old_val = mcause;
            `CSR_MTVAL:    old_val = mtval;
            `CSR_MHARTID:  old_val = `HART_ID;
            default:       addr_known = 1'b0;
        endcase
    end

    // unknown address, access from U, or a write to mhartid
    assign invalid = csr_access & (!addr_known
                                   | (curr_level == priv_isa_types_pkg::PRIV_U)
                                   | (csr_writes & (csr_addr == `CSR_MHARTID)));

    assign invalid_priv_isn = invalid;
    assign csr_rdata        = (csr_access && !invalid) ? old_val : '0;
    assign csr_we           = csr_writes & ~invalid;

    always_comb begin
        if (csr_swap) begin
            new_val = csr_wdata;
        end else if (csr_set) begin
            new_val = old_val | csr_wdata;
        end else begin
            new_val = old_val & ~csr_wdata;
        end
    end

    // only MIE, MPIE and MPP are writable; MPP keeps a legal level
    always_comb begin
        mstatus_wr      = '0;
        mstatus_wr.mie  = new_val[3];
        mstatus_wr.mpie = new_val[7];
        mstatus_wr.mpp  = (new_val[12:11] == 2'b11) ? priv_isa_types_pkg::PRIV_M
                                                    : priv_isa_types_pkg::PRIV_U;
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mstatus  <= '0;
            mtvec    <= `RESET_PC;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (trap_take) begin  // trap beats any CSR write
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= curr_level;
            mepc         <= trap_epc;
            mcause       <= trap_cause;
            mtval        <= trap_val;
        end else if (mret_take) begin
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= priv_isa_types_pkg::PRIV_U;
        end else if (csr_we) begin
            case (csr_addr)
                `CSR_MSTATUS:  mstatus  <= mstatus_wr;
                `CSR_MTVEC:    mtvec    <= {new_val[`XLEN-1:2], 2'b00};  // direct mode only
                `CSR_MSCRATCH: mscratch <= new_val;
                `CSR_MEPC:     mepc     <= {new_val[`XLEN-1:2], 2'b00};
                `CSR_MCAUSE:   mcause   <= new_val;
                `CSR_MTVAL:    mtval    <= new_val;
                default:       ;
            endcase
        end
    end

endmodule

// File: source/priv_int_ex_handler.sv
/* trap arbiter
   gates interrupts, picks the highest-priority event and builds the redirect */
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_int_ex_handler (
    input  logic                            illegal_insn,
    input  logic                            mal_insn,
    input  logic                            breakpoint,
    input  logic                            env,
    input  logic                            mret,
    input  logic [`XLEN-1:0]                epc,
    input  logic [`XLEN-1:0]                badaddr,
    input  logic                            timer_int,
    input  logic                            ext_int,
    input  priv_isa_types_pkg::priv_level_t curr_level,
    input  priv_isa_types_pkg::mstatus_t    mstatus,
    input  logic [`XLEN-1:0]                mtvec,
    input  logic [`XLEN-1:0]                mepc,
    output logic                            trap_take,
    output priv_isa_types_pkg::cause_t      trap_cause,
    output logic [`XLEN-1:0]                trap_epc,
    output logic [`XLEN-1:0]                trap_val,
    output logic                            mret_take,
    output logic                            insert_pc,
    output logic [`XLEN-1:0]                priv_pc,
    output logic                            intr
);

    logic in_u;
    logic int_en;
    logic illegal;

    assign in_u    = (curr_level == priv_isa_types_pkg::PRIV_U);
    assign int_en  = in_u | mstatus.mie;  // U is always interruptible by M
    assign illegal = illegal_insn | (mret & in_u);

    always_comb begin
        trap_take  = 1'b1;
        trap_cause = '0;
        trap_val   = '0;
        mret_take  = 1'b0;
        intr       = 1'b0;
        if (ext_int && int_en) begin
            trap_cause = priv_isa_types_pkg::CAUSE_M_EXT_INT;
            intr       = 1'b1;
        end else if (timer_int && int_en) begin
            trap_cause = priv_isa_types_pkg::CAUSE_M_TIMER_INT;
            intr       = 1'b1;
        end else if (illegal) begin
            trap_cause = priv_isa_types_pkg::CAUSE_ILLEGAL_INSN;
            trap_val   = badaddr;
        end else if (mal_insn) begin
            trap_cause = priv_isa_types_pkg::CAUSE_MISALIGNED_FETCH;
            trap_val   = badaddr;
        end else if (breakpoint) begin
            trap_cause = priv_isa_types_pkg::CAUSE_BREAKPOINT;
        end else if (env) begin
            trap_cause = in_u ? priv_isa_types_pkg::CAUSE_ECALL_U
                              : priv_isa_types_pkg::CAUSE_ECALL_M;
        end else begin
            trap_take = 1'b0;
            mret_take = mret;  // mret from U already trapped above
        end
    end

    assign trap_epc  = epc;
    assign insert_pc = trap_take | mret_take;
    assign priv_pc   = mret_take ? mepc : mtvec;

endmodule

// File: source/priv_block.sv
/* privileged unit top
   ties the CSR file, trap arbiter and mode register to the pipeline */
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_block (
    input  logic                            CLK,
    input  logic                            arst_n,
    input  logic [11:0]                     csr_addr,
    input  logic                            csr_swap,
    input  logic                            csr_set,
    input  logic                            csr_clr,
    input  logic [`XLEN-1:0]                csr_wdata,
    input  logic                            illegal_insn,
    input  logic                            mal_insn,
    input  logic                            breakpoint,
    input  logic                            env,
    input  logic                            mret,
    input  logic [`XLEN-1:0]                epc,
    input  logic [`XLEN-1:0]                badaddr,
    input  logic                            timer_int,
    input  logic                            ext_int,
    output logic [`XLEN-1:0]                csr_rdata,
    output logic                            invalid_priv_isn,
    output logic                            insert_pc,
    output logic [`XLEN-1:0]                priv_pc,
    output logic                            intr,
    output priv_isa_types_pkg::priv_level_t curr_privilege_level
);

    logic                         trap_take;
    priv_isa_types_pkg::cause_t   trap_cause;
    logic [`XLEN-1:0]             trap_epc;
    logic [`XLEN-1:0]             trap_val;
    logic                         mret_take;
    priv_isa_types_pkg::mstatus_t mstatus;
    logic [`XLEN-1:0]             mtvec;
    logic [`XLEN-1:0]             mepc;

    priv_mode mode (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .trap_take  (trap_take),
        .mret_take  (mret_take),
        .mpp        (mstatus.mpp),
        .curr_level (curr_privilege_level)
    );

    priv_csr csr (
        .CLK              (CLK),
        .arst_n           (arst_n),
        .csr_addr         (csr_addr),
        .csr_swap         (csr_swap),
        .csr_set          (csr_set),
        .csr_clr          (csr_clr),
        .csr_wdata        (csr_wdata),
        .curr_level       (curr_privilege_level),
        .trap_take        (trap_take),
        .trap_cause       (trap_cause),
        .trap_epc         (trap_epc),
        .trap_val         (trap_val),
        .mret_take        (mret_take),
        .csr_rdata        (csr_rdata),
        .invalid_priv_isn (invalid_priv_isn),
        .mstatus          (mstatus),
        .mtvec            (mtvec),
        .mepc             (mepc)
    );

    priv_int_ex_handler int_ex_handler (
        .illegal_insn (illegal_insn),
        .mal_insn     (mal_insn),
        .breakpoint   (breakpoint),
        .env          (env),
        .mret         (mret),
        .epc          (epc),
        .badaddr      (badaddr),
        .timer_int    (timer_int),
        .ext_int      (ext_int),
        .curr_level   (curr_privilege_level),
        .mstatus      (mstatus),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .trap_take    (trap_take),
        .trap_cause   (trap_cause),
        .trap_epc     (trap_epc),
        .trap_val     (trap_val),
        .mret_take    (mret_take),
        .insert_pc    (insert_pc),
        .priv_pc      (priv_pc),
        .intr         (intr)
    );

endmodule

// File: verification/priv_clk_gen.sv
/* testbench clock and reset
   10 ns clock, reset held low for the first three cycles */
`timescale 1ns/1ps

module priv_clk_gen (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge CLK);
        #1 arst_n = 1'b1;  // released clear of the edge
    end

endmodule

// File: verification/priv_assertions.sv
/* privileged unit assertions
   reset, interrupt and trap-entry rules checked on the top level */
`timescale 1ns/1ps

module priv_assertions (
    input logic                            CLK,
    input logic                            arst_n,
    input logic                            trap_take,
    input logic                            insert_pc,
    input logic                            intr,
    input priv_isa_types_pkg::priv_level_t curr_privilege_level
);

    // no redirect while the unit is held in reset
    no_redirect_in_reset: assert property (@(posedge CLK) !arst_n |-> !insert_pc)
        else $error("insert_pc high during reset");

    intr_has_redirect: assert property (@(posedge CLK) disable iff (!arst_n)
        intr |-> insert_pc)
        else $error("intr raised without insert_pc");

    // every trap lands in M one cycle later
    trap_enters_m: assert property (@(posedge CLK) disable iff (!arst_n)
        trap_take |=> (curr_privilege_level == priv_isa_types_pkg::PRIV_M))
        else $error("level is not M in the cycle after a trap");

endmodule

bind priv_block priv_assertions chk (
    .CLK                  (CLK),
    .arst_n               (arst_n),
    .trap_take            (trap_take),
    .insert_pc            (insert_pc),
    .intr                 (intr),
    .curr_privilege_level (curr_privilege_level)
);

// File: verification/priv_tb.sv
/* privileged unit testbench
   replays the step table from the test file and checks every step */
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_tb;

    localparam int FIELDS    = 14;  // tokens per step line
    localparam int MAX_STEPS = 64;

    logic                            CLK;
    logic                            arst_n;
    logic [11:0]                     csr_addr;
    logic                            csr_swap;
    logic                            csr_set;
    logic                            csr_clr;
    logic [`XLEN-1:0]                csr_wdata;
    logic                            illegal_insn;
    logic                            mal_insn;
    logic                            breakpoint;
    logic                            env;
    logic                            mret;
    logic [`XLEN-1:0]                epc;
    logic [`XLEN-1:0]                badaddr;
    logic                            timer_int;
    logic                            ext_int;
    logic [`XLEN-1:0]                csr_rdata;
    logic                            invalid_priv_isn;
    logic                            insert_pc;
    logic [`XLEN-1:0]                priv_pc;
    logic                            intr;
    priv_isa_types_pkg::priv_level_t curr_privilege_level;

    logic [31:0] steps [0:FIELDS*MAX_STEPS-1];
    int          seed = 48668;  // seed for random stimulus
    int          n_steps;
    int          n_errors;
    int          cycles;
    int          timeout;

    priv_clk_gen clk_gen (
        .CLK    (CLK),
        .arst_n (arst_n)
    );

    priv_block dut (
        .CLK (CLK), .arst_n (arst_n),
        .csr_addr (csr_addr), .csr_swap (csr_swap), .csr_set (csr_set),
        .csr_clr (csr_clr), .csr_wdata (csr_wdata),
        .illegal_insn (illegal_insn), .mal_insn (mal_insn),
        .breakpoint (breakpoint), .env (env), .mret (mret),
        .epc (epc), .badaddr (badaddr), .timer_int (timer_int), .ext_int (ext_int),
        .csr_rdata (csr_rdata), .invalid_priv_isn (invalid_priv_isn),
        .insert_pc (insert_pc), .priv_pc (priv_pc), .intr (intr),
        .curr_privilege_level (curr_privilege_level)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            n_errors++;
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input priv_isa_types_pkg::priv_level_t exp,
                               input priv_isa_types_pkg::priv_level_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            n_errors++;
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            n_errors++;
            abort_run();
        end
    endtask

    function automatic string csr_name(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS:  return "mstatus";
            `CSR_MTVEC:    return "mtvec";
            `CSR_MSCRATCH: return "mscratch";
            `CSR_MEPC:     return "mepc";
            `CSR_MCAUSE:   return "mcause";
            `CSR_MTVAL:    return "mtval";
            `CSR_MHARTID:  return "mhartid";
            default:       return $sformatf("csr %h", addr);
        endcase
    endfunction

    task automatic apply_step(input int s);
        int b;
        b            = s * FIELDS;
        csr_addr     = steps[b+1][11:0];
        csr_swap     = (steps[b+2] == 1);
        csr_set      = (steps[b+2] == 2);
        csr_clr      = (steps[b+2] == 3);
        csr_wdata    = steps[b+3];
        illegal_insn = steps[b+4][0];
        mal_insn     = steps[b+4][1];
        breakpoint   = steps[b+4][2];
        env          = steps[b+4][3];
        mret         = steps[b+4][4];
        timer_int    = steps[b+5][0];
        ext_int      = steps[b+5][1];
        epc          = steps[b+6];
        badaddr      = steps[b+7];
    endtask

    task automatic check_step(input int s);
        int    b;
        string tag;
        b   = s * FIELDS;
        tag = $sformatf("step %0h %s", steps[b], csr_name(steps[b+1][11:0]));
        check_word({tag, " csr_rdata"}, steps[b+8], csr_rdata);
        check_bit({tag, " invalid_priv_isn"}, steps[b+9][0], invalid_priv_isn);
        check_bit({tag, " insert_pc"}, steps[b+10][0], insert_pc);
        if (steps[b+10][0]) begin  // priv_pc only matters with a redirect
            check_word({tag, " priv_pc"}, steps[b+11], priv_pc);
        end
        check_bit({tag, " intr"}, steps[b+12][0], intr);
        check_level({tag, " level"}, priv_isa_types_pkg::priv_level_t'(steps[b+13][1:0]),
                    curr_privilege_level);
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (timeout > 0 && cycles >= timeout) begin
            $display("timeout after %0d cycles, the step table did not finish", cycles);
            abort_run();
        end
    end

    initial begin
        csr_addr = '0;
        csr_swap = 1'b0;
        csr_set = 1'b0;
        csr_clr = 1'b0;
        csr_wdata = '0;
        illegal_insn = 1'b0;
        mal_insn = 1'b0;
        breakpoint = 1'b0;
        env = 1'b0;
        mret = 1'b0;
        epc = '0;
        badaddr = '0;
        timer_int = 1'b0;
        ext_int = 1'b0;
        n_errors = 0;
        cycles = 0;
        timeout = 0;
        $readmemh("verification/priv_tests.txt", steps);
        n_steps = 0;
        while (n_steps < MAX_STEPS && steps[n_steps*FIELDS] != 32'hffff_ffff) begin
            n_steps++;
        end
        if (n_steps == MAX_STEPS) begin
            $display("no end marker found in the test file");
            abort_run();
        end
        timeout = n_steps + 20;
        @(posedge arst_n);
        for (int s = 0; s < n_steps; s++) begin
            @(posedge CLK);
            #1;
            apply_step(s);
            #7;  // just before the next edge
            check_step(s);
        end
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verification/priv_tests.txt
// id addr op wdata exc irq epc badaddr : rdata invalid insert_pc priv_pc intr level
// op 1 swap 2 set 3 clear; exc bits illegal mal bkpt env mret; irq bits timer ext
01 340 1 12345678 00 0 00000000 00000000 00000000 0 0 00000000 0 3
02 340 2 0000f000 00 0 00000000 00000000 12345678 0 0 00000000 0 3
03 340 3 00000078 00 0 00000000 00000000 1234f678 0 0 00000000 0 3
04 340 2 00000000 00 0 00000000 00000000 1234f600 0 0 00000000 0 3
05 305 1 00000200 00 0 00000000 00000000 00000100 0 0 00000000 0 3
06 305 2 00000040 00 0 00000000 00000000 00000200 0 0 00000000 0 3
07 305 2 00000000 00 0 00000000 00000000 00000240 0 0 00000000 0 3
08 7c0 1 deadbeef 00 0 00000000 00000000 00000000 1 0 00000000 0 3
09 f14 1 00000001 00 0 00000000 00000000 00000000 1 0 00000000 0 3
0a f14 2 00000000 00 0 00000000 00000000 00000000 0 0 00000000 0 3
0b 000 0 00000000 01 0 00001000 0000bad0 00000000 0 1 00000240 0 3
0c 342 2 00000000 00 0 00000000 00000000 00000002 0 0 00000000 0 3
0d 343 2 00000000 00 0 00000000 00000000 0000bad0 0 0 00000000 0 3
0e 341 2 00000000 00 0 00000000 00000000 00001000 0 0 00000000 0 3
0f 000 0 00000000 04 0 00001004 00001234 00000000 0 1 00000240 0 3
10 342 2 00000000 00 0 00000000 00000000 00000003 0 0 00000000 0 3
11 000 0 00000000 08 0 00001008 00000000 00000000 0 1 00000240 0 3
12 342 2 00000000 00 0 00000000 00000000 0000000b 0 0 00000000 0 3
13 300 1 00000080 00 0 00000000 00000000 00001800 0 0 00000000 0 3
14 000 0 00000000 10 0 00000000 00000000 00000000 0 1 00001008 0 3
15 340 2 00000000 00 0 00000000 00000000 00000000 1 0 00000000 0 0
16 000 0 00000000 08 0 00002000 00000000 00000000 0 1 00000240 0 0
17 342 2 00000000 00 0 00000000 00000000 00000008 0 0 00000000 0 3
18 300 2 00000000 00 0 00000000 00000000 00000080 0 0 00000000 0 3
19 000 0 00000000 10 0 00000000 00000000 00000000 0 1 00002000 0 3
1a 000 0 00000000 10 0 00002004 00000000 00000000 0 1 00000240 0 0
1b 342 2 00000000 00 0 00000000 00000000 00000002 0 0 00000000 0 3
1c 300 2 00000000 00 1 00000000 00000000 00000080 0 0 00000000 0 3
1d 300 2 00000008 00 2 00000000 00000000 00000080 0 0 00000000 0 3
1e 000 0 00000000 00 3 00003004 00000000 00000000 0 1 00000240 1 3
1f 342 2 00000000 00 1 00000000 00000000 8000000b 0 0 00000000 0 3
20 300 2 00000008 00 0 00000000 00000000 00001880 0 0 00000000 0 3
21 000 0 00000000 00 1 00003000 00000000 00000000 0 1 00000240 1 3
22 300 1 00000000 00 0 00000000 00000000 00001880 0 0 00000000 0 3
23 000 0 00000000 10 0 00000000 00000000 00000000 0 1 00003000 0 3
24 000 0 00000000 00 1 00004000 00000000 00000000 0 1 00000240 1 0
25 342 2 00000000 00 0 00000000 00000000 80000007 0 0 00000000 0 3
26 000 0 00000000 06 0 00005000 00005002 00000000 0 1 00000240 0 3
27 343 2 00000000 00 0 00000000 00000000 00005002 0 0 00000000 0 3
// end of table
ffffffff

// File: list.f
+incdir+include
source/priv_isa_types_pkg.sv
source/priv_mode.sv
source/priv_csr.sv
source/priv_int_ex_handler.sv
source/priv_block.sv
verification/priv_clk_gen.sv
verification/priv_assertions.sv
verification/priv_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps
TOP       := priv_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
